// ==== design/trace_pkg.sv ====
//////////////////////////////
// Pipeline trace monitor package
// Opcode class enum
// Data, stall and cycle widths
//////////////////////////////

package trace_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    parameter int XLEN    = 32; // Instr word, result, address, wb data
    parameter int STALL_W = 4;  // Per-instruction stall counter
    parameter int CYC_W   = 16; // Cycle counter and latency, both wrap

    // Stall counter ceiling
    parameter logic [STALL_W-1:0] STALL_MAX = {STALL_W{1'b1}};

    //////////////////////////////
    // Opcode classes
    //////////////////////////////
    // Encodings 6 and 7 are unused and flagged in the store
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0, // Register/immediate arithmetic
        OP_LOAD   = 3'd1, // Memory read
        OP_STORE  = 3'd2, // Memory write
        OP_BRANCH = 3'd3, // Conditional branch
        OP_JUMP   = 3'd4, // Unconditional jump
        OP_SYSTEM = 3'd5  // CSR, ecall and friends
    } op_e;

endpackage

// ==== design/stage_id_tracker.sv ====
//////////////////////////////
// Stage ID tracker
// Five-stage valid and ID shift, stall rule
// Free-running cycle counter
//////////////////////////////

`timescale 1ns/1ps

module stage_id_tracker #(
    parameter int DEPTH = 8 // Record table depth, power of two
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,          // Decode stall level
    output logic                       fetch_valid,
    output logic                       decode_valid,
    output logic                       exec_valid,
    output logic                       mem_valid,
    output logic                       wb_valid,
    output logic [$clog2(DEPTH)-1:0]   fetch_id,
    output logic [$clog2(DEPTH)-1:0]   decode_id,
    output logic [$clog2(DEPTH)-1:0]   exec_id,
    output logic [$clog2(DEPTH)-1:0]   mem_id,
    output logic [$clog2(DEPTH)-1:0]   wb_id,
    output logic                       decode_stalled, // Decode holds a live instr this edge
    output logic [trace_pkg::CYC_W-1:0] cycle
);

    localparam int ID_W = $clog2(DEPTH);

    //////////////////////////////
    // Valid and ID shift
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid  <= 1'b0;
            decode_valid <= 1'b0;
            exec_valid   <= 1'b0;
            mem_valid    <= 1'b0;
            wb_valid     <= 1'b0;
            fetch_id     <= '0;
            decode_id    <= '0;
            exec_id      <= '0;
            mem_id       <= '0;
            wb_id        <= '0;
        end else begin
            fetch_valid <= 1'b1; // Fetch never runs dry once out of reset

            // Back half always moves
            mem_valid <= exec_valid;
            mem_id    <= exec_id;
            wb_valid  <= mem_valid;
            wb_id     <= mem_id;
            exec_id   <= decode_id;

            if (stall) begin
                exec_valid <= 1'b0; // Bubble into execute, fetch/decode hold
            end else begin
                exec_valid   <= decode_valid;
                decode_valid <= fetch_valid;
                decode_id    <= fetch_id;
                fetch_id     <= fetch_id + ID_W'(1); // Wraps modulo DEPTH
            end
        end
    end

    assign decode_stalled = stall && decode_valid;

    // Cycle stamp source for fetch and retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // A live ID must never be reused while still in memory
    a_id_unique: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_valid && mem_valid) |-> (mem_id != fetch_id));

endmodule

// ==== design/trace_store.sv ====
//////////////////////////////
// Trace record store
// ID-indexed record table, written per stage
// Combinational write-back record read
//////////////////////////////

`timescale 1ns/1ps

module trace_store #(
    parameter int DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Tracker side
    input  logic                          fetch_valid,
    input  logic                          decode_valid,
    input  logic                          exec_valid,
    input  logic                          mem_valid,
    input  logic [$clog2(DEPTH)-1:0]      fetch_id,
    input  logic [$clog2(DEPTH)-1:0]      decode_id,
    input  logic [$clog2(DEPTH)-1:0]      exec_id,
    input  logic [$clog2(DEPTH)-1:0]      mem_id,
    input  logic [$clog2(DEPTH)-1:0]      wb_id,
    input  logic                          decode_stalled,
    input  logic [trace_pkg::CYC_W-1:0]   cycle,
    // Pipeline values
    input  logic [trace_pkg::XLEN-1:0]    fetch_instr,
    input  trace_pkg::op_e                decode_op,
    input  logic [trace_pkg::XLEN-1:0]    exec_result,
    input  logic [trace_pkg::XLEN-1:0]    mem_addr,
    input  logic [trace_pkg::XLEN-1:0]    wb_data,
    // Write-back record
    output logic [trace_pkg::XLEN-1:0]    rec_instr,
    output trace_pkg::op_e                rec_op,
    output logic [trace_pkg::XLEN-1:0]    rec_result,
    output logic [trace_pkg::XLEN-1:0]    rec_addr,
    output logic [trace_pkg::XLEN-1:0]    rec_data,
    output logic [trace_pkg::STALL_W-1:0] rec_stalls,
    output logic [trace_pkg::CYC_W-1:0]   rec_stamp
);

    //////////////////////////////
    // Record table
    //////////////////////////////
    logic [trace_pkg::XLEN-1:0]    instr_tab  [DEPTH];
    trace_pkg::op_e                op_tab     [DEPTH];
    logic [trace_pkg::XLEN-1:0]    result_tab [DEPTH];
    logic [trace_pkg::XLEN-1:0]    addr_tab   [DEPTH];
    logic [trace_pkg::STALL_W-1:0] stalls_tab [DEPTH];
    logic [trace_pkg::CYC_W-1:0]   stamp_tab  [DEPTH];

    logic mem_is_ls; // Entry in memory was decoded as load or store

    assign mem_is_ls = (op_tab[mem_id] == trace_pkg::OP_LOAD) ||
                       (op_tab[mem_id] == trace_pkg::OP_STORE);

    always_ff @(posedge clk) begin
        // Fetch rewrites while held, last write is the advance edge
        if (fetch_valid) begin
            instr_tab[fetch_id]  <= fetch_instr;
            stamp_tab[fetch_id]  <= cycle;
            stalls_tab[fetch_id] <= '0;    // Fresh entry
        end

        if (decode_valid) begin
            op_tab[decode_id] <= decode_op;
        end
        // One count per stalled edge, sticks at max
        if (decode_stalled && (stalls_tab[decode_id] != trace_pkg::STALL_MAX)) begin
            stalls_tab[decode_id] <= stalls_tab[decode_id] + 1'b1;
        end

        if (exec_valid) begin
            result_tab[exec_id] <= exec_result;
        end

        if (mem_valid) begin
            addr_tab[mem_id] <= mem_is_ls ? mem_addr : '0; // Only loads/stores keep an address
        end
    end

    //////////////////////////////
    // Write-back read port
    //////////////////////////////
    assign rec_instr  = instr_tab[wb_id];
    assign rec_op     = op_tab[wb_id];
    assign rec_result = result_tab[wb_id];
    assign rec_addr   = addr_tab[wb_id];
    assign rec_stalls = stalls_tab[wb_id];
    assign rec_stamp  = stamp_tab[wb_id];
    assign rec_data   = wb_data; // Captured by the reporter on the wb edge

    // Decoder must hand over a defined class
    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        decode_valid |-> decode_op inside {trace_pkg::OP_ALU, trace_pkg::OP_LOAD,
                                           trace_pkg::OP_STORE, trace_pkg::OP_BRANCH,
                                           trace_pkg::OP_JUMP, trace_pkg::OP_SYSTEM});

endmodule

// ==== design/retire_reporter.sv ====
//////////////////////////////
// Retire reporter
// Registered retire record, latency
// Retirement counter
//////////////////////////////

`timescale 1ns/1ps

module retire_reporter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_valid,       // Record below is retiring
    input  logic [trace_pkg::CYC_W-1:0]   cycle,
    input  logic [trace_pkg::XLEN-1:0]    rec_instr,
    input  trace_pkg::op_e                rec_op,
    input  logic [trace_pkg::XLEN-1:0]    rec_result,
    input  logic [trace_pkg::XLEN-1:0]    rec_addr,
    input  logic [trace_pkg::XLEN-1:0]    rec_data,
    input  logic [trace_pkg::STALL_W-1:0] rec_stalls,
    input  logic [trace_pkg::CYC_W-1:0]   rec_stamp,
    output logic                          retire_valid,   // One pulse per instr
    output logic [trace_pkg::XLEN-1:0]    retire_instr,
    output trace_pkg::op_e                retire_op,
    output logic [trace_pkg::XLEN-1:0]    retire_result,
    output logic [trace_pkg::XLEN-1:0]    retire_addr,
    output logic [trace_pkg::XLEN-1:0]    retire_data,
    output logic [trace_pkg::STALL_W-1:0] retire_stalls,
    output logic [trace_pkg::CYC_W-1:0]   retire_latency,
    output logic [trace_pkg::CYC_W-1:0]   retire_count
);

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= wb_valid;
            if (wb_valid) begin
                retire_count <= retire_count + 1'b1; // Wraps like the cycle count
            end
        end
    end

    // Payload, loaded only on a retiring edge
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_instr   <= rec_instr;
            retire_op      <= rec_op;
            retire_result  <= rec_result;
            retire_addr    <= rec_addr;
            retire_data    <= rec_data;
            retire_stalls  <= rec_stalls;
            retire_latency <= cycle - rec_stamp; // Fetch edge to wb edge, modulo wrap
        end
    end

    // Nothing retires sooner than four edges after its fetch
    a_latency_floor: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire_latency >= trace_pkg::CYC_W'(4)));

endmodule

// ==== design/pipe_trace_top.sv ====
//////////////////////////////
// Pipeline trace monitor top
// Tracker, record store, reporter
//////////////////////////////

`timescale 1ns/1ps

module pipe_trace_top #(
    parameter int DEPTH = 8 // Record slots, power of two, at least 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic [trace_pkg::XLEN-1:0]    fetch_instr,
    input  trace_pkg::op_e                decode_op,
    input  logic [trace_pkg::XLEN-1:0]    exec_result,
    input  logic [trace_pkg::XLEN-1:0]    mem_addr,
    input  logic [trace_pkg::XLEN-1:0]    wb_data,
    output logic                          retire_valid,
    output logic [trace_pkg::XLEN-1:0]    retire_instr,
    output trace_pkg::op_e                retire_op,
    output logic [trace_pkg::XLEN-1:0]    retire_result,
    output logic [trace_pkg::XLEN-1:0]    retire_addr,
    output logic [trace_pkg::XLEN-1:0]    retire_data,
    output logic [trace_pkg::STALL_W-1:0] retire_stalls,
    output logic [trace_pkg::CYC_W-1:0]   retire_latency,
    output logic [trace_pkg::CYC_W-1:0]   retire_count
);

    localparam int ID_W = $clog2(DEPTH);

    // Tracker outputs
    logic                        fetch_valid, decode_valid, exec_valid, mem_valid, wb_valid;
    logic [ID_W-1:0]             fetch_id, decode_id, exec_id, mem_id, wb_id;
    logic                        decode_stalled;
    logic [trace_pkg::CYC_W-1:0] cycle;

    // Write-back record
    logic [trace_pkg::XLEN-1:0]    rec_instr, rec_result, rec_addr, rec_data;
    trace_pkg::op_e                rec_op;
    logic [trace_pkg::STALL_W-1:0] rec_stalls;
    logic [trace_pkg::CYC_W-1:0]   rec_stamp;

    stage_id_tracker #(.DEPTH(DEPTH)) u_tracker (
        .clk, .rst_n, .stall,
        .fetch_valid, .decode_valid, .exec_valid, .mem_valid, .wb_valid,
        .fetch_id, .decode_id, .exec_id, .mem_id, .wb_id,
        .decode_stalled, .cycle
    );

    trace_store #(.DEPTH(DEPTH)) u_store (
        .clk, .rst_n,
        .fetch_valid, .decode_valid, .exec_valid, .mem_valid,
        .fetch_id, .decode_id, .exec_id, .mem_id, .wb_id,
        .decode_stalled, .cycle,
        .fetch_instr, .decode_op, .exec_result, .mem_addr, .wb_data,
        .rec_instr, .rec_op, .rec_result, .rec_addr, .rec_data, .rec_stalls, .rec_stamp
    );

    retire_reporter u_reporter (
        .clk, .rst_n, .wb_valid, .cycle,
        .rec_instr, .rec_op, .rec_result, .rec_addr, .rec_data, .rec_stalls, .rec_stamp,
        .retire_valid, .retire_instr, .retire_op, .retire_result, .retire_addr,
        .retire_data, .retire_stalls, .retire_latency, .retire_count
    );

endmodule

// ==== verification/pipe_trace_checks.sv ====
//////////////////////////////
// Retire record checker
// Expected-record queue fed by the reference pipeline
// Field, pulse and count assertions
//////////////////////////////

`timescale 1ns/1ps

module pipe_trace_checks (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          exp_valid,       // Model wb slot holds an instr
    input  logic [trace_pkg::XLEN-1:0]    exp_instr,
    input  trace_pkg::op_e                exp_op,
    input  logic [trace_pkg::XLEN-1:0]    exp_result,
    input  logic [trace_pkg::XLEN-1:0]    exp_addr,
    input  logic [trace_pkg::XLEN-1:0]    exp_data,        // wb_data as driven on the wb edge
    input  int                            exp_stall_edges, // Raw stalled edges in decode
    input  logic                          retire_valid,
    input  logic [trace_pkg::XLEN-1:0]    retire_instr,
    input  trace_pkg::op_e                retire_op,
    input  logic [trace_pkg::XLEN-1:0]    retire_result,
    input  logic [trace_pkg::XLEN-1:0]    retire_addr,
    input  logic [trace_pkg::XLEN-1:0]    retire_data,
    input  logic [trace_pkg::STALL_W-1:0] retire_stalls,
    input  logic [trace_pkg::CYC_W-1:0]   retire_latency,
    input  logic [trace_pkg::CYC_W-1:0]   retire_count,
    output int                            errors,
    output int                            retired
);

    typedef struct packed {
        logic [trace_pkg::XLEN-1:0] instr;
        trace_pkg::op_e             op;
        logic [trace_pkg::XLEN-1:0] result;
        logic [trace_pkg::XLEN-1:0] addr;
        logic [trace_pkg::XLEN-1:0] data;
        logic [31:0]                stall_edges;
    } rec_t;

    localparam logic [31:0] SAT = (1 << trace_pkg::STALL_W) - 1; // Stall count ceiling

    rec_t exp_q[$];          // Records owed, oldest first
    rec_t head;
    logic [31:0] exp_stalls; // Stall count owed by the head record
    int   err_cnt   = 0;
    int   ret_cnt   = 0;
    int   since_rst = 0;     // Retirements since the last reset edge
    logic pulse_due = 1'b0;  // A retire pulse is owed now
    logic armed     = 1'b0;  // Set once the first reset edge is seen

    task automatic flag_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("ERR %0t %s expected %h got %h", $time, name, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("%0t: %s", $time, what);
        err_cnt++;
    endtask

    //////////////////////////////
    // Per-edge checks
    //////////////////////////////
    always @(posedge clk) begin
        if (armed) begin
            assert (retire_valid == pulse_due)
                else flag_mismatch("retire_valid", 32'(pulse_due), 32'(retire_valid));
        end
        if (retire_valid === 1'b1) begin
            ret_cnt++;
            since_rst++;
            assert (retire_count == 16'(since_rst))
                else flag_mismatch("retire_count", 32'(since_rst), 32'(retire_count));
            if (exp_q.size() == 0) begin
                note_failure("retire pulse arrived with no instruction due to retire");
            end else begin
                head = exp_q.pop_front();
                assert (retire_instr == head.instr)
                    else flag_mismatch("retire_instr", head.instr, retire_instr);
                assert (retire_op == head.op)
                    else flag_mismatch("retire_op", 32'(head.op), 32'(retire_op));
                assert (retire_result == head.result)
                    else flag_mismatch("retire_result", head.result, retire_result);
                assert (retire_addr == head.addr)
                    else flag_mismatch("retire_addr", head.addr, retire_addr);
                assert (retire_data == head.data)
                    else flag_mismatch("retire_data", head.data, retire_data);
                // Count sticks at the ceiling, latency keeps growing
                exp_stalls = (head.stall_edges > SAT) ? SAT : head.stall_edges;
                assert (32'(retire_stalls) == exp_stalls)
                    else flag_mismatch("retire_stalls", exp_stalls, 32'(retire_stalls));
                assert (retire_latency == 16'(32'd4 + head.stall_edges))
                    else flag_mismatch("retire_latency", 32'd4 + head.stall_edges,
                                       32'(retire_latency));
            end
        end
        if (!rst_n) begin
            exp_q.delete();  // In-flight records are lost
            since_rst = 0;
        end else if (exp_valid) begin
            exp_q.push_back('{exp_instr, exp_op, exp_result, exp_addr, exp_data,
                              32'(exp_stall_edges)});
        end
        pulse_due <= rst_n && exp_valid;
        armed     <= armed || !rst_n;
        errors    <= err_cnt;
        retired   <= ret_cnt;
    end

    // Reporter must come out of reset quiet
    a_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
        else note_failure("retire pulse right after a reset edge");

endmodule

// ==== verification/pipe_trace_tb.sv ====
//////////////////////////////
// Pipeline trace monitor testbench
// Clock, reset, random stimulus
// Reference five-stage model, timeout, summary
//////////////////////////////

`timescale 1ns/1ps

module pipe_trace_tb;

    localparam int DEPTH   = 8;
    localparam int RUN_CYC = 16 + 20 + 30 + 18 + 60 + 22 + 24 + 6 * 12; // Reset, tests, drains
    localparam int LIMIT   = RUN_CYC + 50;

    logic clk, rst_n, stall;
    logic [trace_pkg::XLEN-1:0] fetch_instr, exec_result, mem_addr, wb_data;
    trace_pkg::op_e decode_op;
    logic retire_valid;
    logic [trace_pkg::XLEN-1:0] retire_instr, retire_result, retire_addr, retire_data;
    trace_pkg::op_e retire_op;
    logic [trace_pkg::STALL_W-1:0] retire_stalls;
    logic [trace_pkg::CYC_W-1:0] retire_latency, retire_count;

    // Reference pipeline slots, fetch only needs a valid
    logic f_valid = 1'b0, d_valid = 1'b0, e_valid = 1'b0, m_valid = 1'b0, w_valid = 1'b0;
    logic [trace_pkg::XLEN-1:0] d_instr, e_instr, m_instr, w_instr, m_result, w_result, w_addr;
    trace_pkg::op_e e_op = trace_pkg::OP_ALU, m_op = trace_pkg::OP_ALU, w_op = trace_pkg::OP_ALU;
    int d_stl = 0, e_stl = 0, m_stl = 0, w_stl = 0; // Stalled edges spent in decode

    int launched = 0, dropped = 0, cyc = 0;         // Launch and loss bookkeeping
    int errors, retired, err_mark = 0, ret_mark = 0;
    logic [31:0] rng = 32'heffd_c5c6;

    pipe_trace_top #(.DEPTH(DEPTH)) UUT (
        .clk, .rst_n, .stall, .fetch_instr, .decode_op, .exec_result, .mem_addr, .wb_data,
        .retire_valid, .retire_instr, .retire_op, .retire_result, .retire_addr,
        .retire_data, .retire_stalls, .retire_latency, .retire_count
    );

    pipe_trace_checks chk (
        .clk, .rst_n, .exp_valid(w_valid), .exp_instr(w_instr), .exp_op(w_op),
        .exp_result(w_result), .exp_addr(w_addr), .exp_data(wb_data), .exp_stall_edges(w_stl),
        .retire_valid, .retire_instr, .retire_op, .retire_result, .retire_addr,
        .retire_data, .retire_stalls, .retire_latency, .retire_count, .errors, .retired
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout after %0d cycles, retirements stopped arriving", cyc);
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // Reference pipeline
    //////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            dropped <= dropped + int'(d_valid) + int'(e_valid) + int'(m_valid) + int'(w_valid);
            {f_valid, d_valid, e_valid, m_valid, w_valid} <= '0;
        end else begin
            w_valid  <= m_valid;   // Back half always moves
            w_instr  <= m_instr;
            w_op     <= m_op;
            w_result <= m_result;
            w_stl    <= m_stl;
            w_addr   <= (m_op == trace_pkg::OP_LOAD || m_op == trace_pkg::OP_STORE) ? mem_addr : '0;
            m_valid  <= e_valid;
            m_instr  <= e_instr;
            m_op     <= e_op;
            m_stl    <= e_stl;
            m_result <= exec_result; // Result sampled as execute drains
            f_valid  <= 1'b1;
            if (stall) begin
                e_valid <= 1'b0;      // Bubble
                if (d_valid) d_stl <= d_stl + 1;
            end else begin
                e_valid <= d_valid;
                e_instr <= d_instr;
                e_op    <= decode_op; // Class as decode hands over
                e_stl   <= d_stl;
                d_valid <= f_valid;
                d_instr <= fetch_instr;
                d_stl   <= 0;
                if (f_valid) launched <= launched + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // One edge of stimulus, op_sel below zero picks a random class
    task automatic drive_cycle(input logic stall_v, input int op_sel);
        @(posedge clk);
        stall <= stall_v;
        rng = xorshift32(rng);
        fetch_instr <= rng;
        rng = xorshift32(rng);
        exec_result <= rng;
        rng = xorshift32(rng);
        mem_addr <= rng;
        rng = xorshift32(rng);
        wb_data <= rng;
        rng = xorshift32(rng);
        decode_op <= trace_pkg::op_e'(3'((op_sel < 0) ? rng % 32'd6 : 32'(op_sel)));
    endtask

    // Run clean edges until every launched instr has retired or been lost
    task automatic drain_pipe;
        int target;
        drive_cycle(1'b0, -1);
        drive_cycle(1'b0, -1);
        target = launched;
        while (retired + dropped < target) drive_cycle(1'b0, -1);
    endtask

    task automatic close_test(input string name);
        drain_pipe();
        $display("Test %s done: %0d retired, %0d errors", name, retired - ret_mark,
                 errors - err_mark);
        ret_mark = retired;
        err_mark = errors;
    endtask

    initial begin
        int len;
        int n;
        int adv;
        int stall_budget;
        logic st;
        rst_n = 1'b0;
        stall = 1'b0;
        fetch_instr = '0;
        decode_op = trace_pkg::OP_ALU;
        exec_result = '0;
        mem_addr = '0;
        wb_data = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (20) drive_cycle(1'b0, -1);
        close_test("1 no stalls");

        for (len = 1; len <= 3; len++) begin
            repeat (2) begin
                repeat (len) drive_cycle(1'b1, -1);
                repeat (3) drive_cycle(1'b0, -1);
            end
        end
        close_test("2 stall runs");

        for (n = 0; n < 18; n++) drive_cycle(1'b0, n % 6); // Every class in turn
        close_test("3 address by class");

        adv = 0;
        stall_budget = 20;
        while (adv < 40) begin
            st = (rng[5:4] == 2'b00) && (stall_budget > 0);
            if (st) stall_budget--;
            else adv++;
            drive_cycle(st, -1);
        end
        close_test("4 ID wrap");

        repeat (2) drive_cycle(1'b0, -1);
        repeat (20) drive_cycle(1'b1, -1); // Long enough to pin the count
        close_test("5 stall saturation");

        repeat (8) drive_cycle(1'b0, -1);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) drive_cycle(1'b0, -1);
        rst_n <= 1'b1;
        repeat (12) drive_cycle(1'b0, -1);
        close_test("6 reset mid-run");

        repeat (2) @(posedge clk);
        $display("Summary: 6 tests, %0d retired, %0d errors", retired, errors);
        if (errors == 0 && retired > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/trace_pkg.sv
design/stage_id_tracker.sv
design/trace_store.sv
design/retire_reporter.sv
design/pipe_trace_top.sv
verification/pipe_trace_checks.sv
verification/pipe_trace_tb.sv

// ==== Makefile ====
# Pipeline trace monitor, Verilator flow
TOP = pipe_trace_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

# Pass only if the run prints the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /All tests passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
